// ==== bench/rv_core_assert.sv ====
// Core memory port assertions
`timescale 1ns/1ps

module rv_core_assert (
    input logic        clk,
    input logic        rst,
    input logic        cpu_stall,
    input logic [31:0] im_addr,
    input logic [31:0] dm_addr,
    input logic [31:0] dm_wdata,
    input logic [3:0]  dm_wstrb,
    input logic        dm_write,
    input logic        dm_read
);

    // One data access at a time
    assert property (@(posedge clk) disable iff (rst) !(dm_read && dm_write))
        else $error("dm_read and dm_write high together");

    assert property (@(posedge clk) disable iff (rst) im_addr[1:0] == 2'b00)
        else $error("im_addr not word aligned");

    // Strobes only with a write
    assert property (@(posedge clk) disable iff (rst) !dm_write |-> dm_wstrb == 4'b0000)
        else $error("dm_wstrb active without dm_write");

    // Frozen pipeline holds every output
    assert property (@(posedge clk) disable iff (rst)
        cpu_stall |=> $stable({im_addr, dm_addr, dm_wdata, dm_wstrb, dm_write, dm_read}))
        else $error("Outputs moved during cpu_stall");

endmodule

// ==== bench/tb_rv_core.sv ====
// RV32I core testbench
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t RESET_PC       = 32'h0000_0000;
    localparam int    CLK_PERIOD     = 100;
    localparam int    RESET_CYCLES   = 4;
    // Cycle budgets per test
    localparam int    ALU_CYCLES     = 80;
    localparam int    FWD_CYCLES     = 60;
    localparam int    BYTE_CYCLES    = 60;
    localparam int    BRANCH_CYCLES  = 80;
    localparam int    STALL_CYCLES   = 200;
    localparam int    WATCHDOG_CYCLES = ALU_CYCLES + 2 * FWD_CYCLES + BYTE_CYCLES
                                       + BRANCH_CYCLES + STALL_CYCLES
                                       + 6 * (RESET_CYCLES + 1) + 100;

    logic       clk = 1'b0;
    logic       rst;
    logic       cpu_stall;
    word_t      im_addr;
    word_t      im_rdata;
    word_t      dm_addr;
    word_t      dm_wdata;
    logic [3:0] dm_wstrb;
    logic       dm_write;
    logic       dm_read;
    word_t      dm_rdata;

    word_t      imem [0:63];
    logic [7:0] dmem [0:511];
    word_t      prog [$];
    word_t      addr_q [$];
    word_t      exp_q [$];
    word_t      saved_q [$];
    int         seed;

    rv_core #(.RESET_PC(RESET_PC)) i_dut (.*);

    bind rv_core rv_core_assert i_assert (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Combinational reads with the data port answering only dm_read
    assign im_rdata = imem[im_addr[7:2]];
    assign dm_rdata = !dm_read ? 32'd0 :
                      {dmem[{dm_addr[8:2], 2'd3}], dmem[{dm_addr[8:2], 2'd2}],
                       dmem[{dm_addr[8:2], 2'd1}], dmem[{dm_addr[8:2], 2'd0}]};

    // Write commits only on an unstalled edge
    always @(posedge clk) begin
        if (dm_write && !cpu_stall) begin
            for (int b = 0; b < 4; b++) begin
                if (dm_wstrb[b]) dmem[{dm_addr[8:2], 2'(b)}] <= dm_wdata[8*b +: 8];
            end
        end
    end

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a ^ (a >> 3) ^ 8'h5A);
    endfunction

    function automatic word_t fill_word(input int a);
        return {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)};
    endfunction

    function automatic word_t mem_word(input word_t a);
        return {dmem[a + 3], dmem[a + 2], dmem[a + 1], dmem[a]};
    endfunction

    // Instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_RTYPE};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Operation index to funct3 in the order add sub and or xor slt sltu sll srl sra
    function automatic logic [2:0] alu_f3(input int k);
        case (k)
            0, 1: return F3_ADD;
            2: return F3_AND;
            3: return F3_OR;
            4: return F3_XOR;
            5: return F3_SLT;
            6: return F3_SLTU;
            7: return F3_SLL;
            default: return F3_SRL;
        endcase
    endfunction

    // ISA results for the same index
    function automatic word_t isa_alu(input int k, input word_t a, input word_t b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return {31'd0, $signed(a) < $signed(b)};
            6: return {31'd0, a < b};
            7: return a << b[4:0];
            8: return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    function automatic logic branch_taken(input int k, input word_t a, input word_t b);
        case (k)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic emit(input word_t instr);
        prog.push_back(instr);
    endtask

    // sw of rs to addr and the word memory must hold afterwards
    task automatic store_expect(input reg_idx_t rs, input word_t addr, input word_t value);
        emit(s_type(addr[11:0], rs, F3_WORD));
        addr_q.push_back(addr);
        exp_q.push_back(value);
    endtask

    task automatic new_program();
        prog.delete();
        addr_q.delete();
        exp_q.delete();
    endtask

    task automatic run_program(input int budget, input bit random_stall);
        @(negedge clk);
        rst = 1'b1;
        cpu_stall = 1'b0;
        // Trailing jal to self
        emit(j_type(21'd0, 5'd0));
        for (int i = 0; i < 64; i++) imem[i] = (i < prog.size()) ? prog[i] : NOP_INSTR;
        for (int i = 0; i < 512; i++) dmem[i] = fill_byte(i);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check("reset im_addr", RESET_PC, im_addr);
        check("reset dm strobes", 32'd0, {30'd0, dm_read, dm_write});
        repeat (budget) begin
            @(negedge clk);
            if (random_stall) cpu_stall = (($random(seed) & 3) == 0);
        end
        cpu_stall = 1'b0;
    endtask

    task automatic verify(input string name);
        for (int i = 0; i < addr_q.size(); i++) check(name, exp_q[i], mem_word(addr_q[i]));
    endtask

    task automatic alu_and_lui();
        word_t a;
        word_t b;
        int    n;
        a = 32'hF0F0_F123;
        n = 0;
        new_program();
        emit({20'hF0F0F, 5'd1, OPC_LUI});
        emit(i_type(12'h123, 1, F3_ADD, 1, OPC_ITYPE));
        emit(i_type(12'd13, 0, F3_ADD, 2, OPC_ITYPE));
        for (int k = 0; k < 10; k++) begin
            emit(r_type((k == 1 || k == 9) ? 7'h20 : 7'h00, 2, 1, alu_f3(k), 3));
            store_expect(3, 4 * n, isa_alu(k, a, 32'd13));
            n++;
        end
        for (int k = 0; k < 10; k++) begin
            if (k != 1) begin
                b = (k >= 7) ? 32'd7 : 32'hFFFF_FED4;
                emit(i_type((k == 9) ? 12'h407 : b[11:0], 1, alu_f3(k), 3, OPC_ITYPE));
                store_expect(3, 4 * n, isa_alu(k, a, b));
                n++;
            end
        end
        emit({20'hABCDE, 5'd3, OPC_LUI});
        store_expect(3, 4 * n, 32'hABCD_E000);
        run_program(ALU_CYCLES, 1'b0);
        verify("alu");
    endtask

    // Dependent chain with a load feeding its consumer
    task automatic forwarding_program();
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        a = 32'd5;
        b = a + 32'd3;
        c = b + a;
        d = c - b;
        new_program();
        emit(i_type(12'd5, 0, F3_ADD, 1, OPC_ITYPE));
        emit(i_type(12'd3, 1, F3_ADD, 2, OPC_ITYPE));
        emit(r_type(7'h00, 1, 2, F3_ADD, 3));
        emit(r_type(7'h20, 2, 3, F3_ADD, 4));
        store_expect(4, 32'h40, d);
        emit(i_type(12'h40, 0, F3_WORD, 5, OPC_LOAD));
        emit(r_type(7'h00, 3, 5, F3_ADD, 6));
        store_expect(6, 32'h44, d + c);
        store_expect(3, 32'h48, c);
        emit(r_type(7'h00, 4, 6, F3_XOR, 7));
        store_expect(7, 32'h4C, (d + c) ^ d);
        emit(i_type(12'h44, 0, F3_WORD, 8, OPC_LOAD));
        store_expect(8, 32'h50, d + c);
    endtask

    task automatic dependent_chain();
        forwarding_program();
        run_program(FWD_CYCLES, 1'b0);
        verify("forwarding");
        // Whole data memory image for the stalled rerun
        saved_q.delete();
        for (int a = 0; a < 512; a += 4) begin
            saved_q.push_back(mem_word(a));
        end
    endtask

    task automatic byte_access();
        logic [7:0] v [4];
        v = '{8'h81, 8'h7F, 8'hC3, 8'h15};
        new_program();
        for (int i = 0; i < 4; i++) begin
            emit(i_type({4'd0, v[i]}, 0, F3_ADD, 1, OPC_ITYPE));
            emit(s_type(12'h60 + 12'(i), 1, F3_BYTE));
        end
        emit(i_type(12'h60, 0, F3_WORD, 2, OPC_LOAD));
        store_expect(2, 32'h70, {v[3], v[2], v[1], v[0]});
        for (int i = 0; i < 4; i++) begin
            emit(i_type(12'h60 + 12'(i), 0, F3_BYTE, 3, OPC_LOAD));
            store_expect(3, 32'h74 + 4 * i, {{24{v[i][7]}}, v[i]});
        end
        emit(i_type(12'h60, 0, F3_LBU, 4, OPC_LOAD));
        store_expect(4, 32'h84, {24'd0, v[0]});
        emit(i_type(12'h62, 0, F3_LBU, 4, OPC_LOAD));
        store_expect(4, 32'h88, {24'd0, v[2]});
        // Neighbouring word keeps its fill
        addr_q.push_back(32'h64);
        exp_q.push_back(fill_word(32'h64));
        run_program(BYTE_CYCLES, 1'b0);
        verify("byte access");
    endtask

    task automatic branches_and_jal();
        word_t    val [3];
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    addr;
        word_t    jal_pc;
        val = '{32'd0, 32'd5, 32'hFFFF_FFFD};
        addr = 32'h100;
        new_program();
        emit(i_type(12'd5, 0, F3_ADD, 1, OPC_ITYPE));
        emit(i_type(12'hFFD, 0, F3_ADD, 2, OPC_ITYPE));
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 4; k++) begin
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : 5'd1;
                emit(b_type(13'd8, rs2, rs1, (k == 0) ? F3_BEQ : (k == 1) ? F3_BNE :
                                             (k == 2) ? F3_BLT : F3_BGE));
                store_expect(1, addr, branch_taken(k, val[rs1], val[rs2]) ?
                                      fill_word(addr) : 32'd5);
                addr += 4;
            end
        end
        // Taken branch over two stores
        emit(b_type(13'd12, 1, 1, F3_BEQ));
        store_expect(1, addr, fill_word(addr));
        store_expect(1, addr + 4, fill_word(addr + 4));
        jal_pc = 4 * prog.size();
        emit(j_type(21'd8, 5));
        store_expect(1, addr + 8, fill_word(addr + 8));
        store_expect(5, addr + 12, jal_pc + 4);
        run_program(BRANCH_CYCLES, 1'b0);
        verify("branch");
    endtask

    task automatic backpressure();
        forwarding_program();
        run_program(STALL_CYCLES, 1'b1);
        verify("backpressure");
        foreach (saved_q[i]) begin
            check("backpressure vs forwarding", saved_q[i], mem_word(4 * i));
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $fatal(1, "Timeout");
    end

    initial begin
        seed = 30559;
        rst = 1'b1;
        cpu_stall = 1'b0;
        alu_and_lui();
        dependent_chain();
        byte_access();
        branches_and_jal();
        backpressure();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== design/decode_stage.sv ====
// Instruction decode and register file
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_stall,
    input  logic              redirect,
    input  rv_pkg::word_t     if_id_pc,
    input  rv_pkg::word_t     if_id_instr,
    input  logic              wb_en,
    input  rv_pkg::reg_idx_t  wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              hazard_stall,
    output rv_pkg::word_t     id_ex_pc,
    output rv_pkg::word_t     id_ex_rs1_data,
    output rv_pkg::word_t     id_ex_rs2_data,
    output rv_pkg::word_t     id_ex_imm,
    output rv_pkg::reg_idx_t  id_ex_rs1,
    output rv_pkg::reg_idx_t  id_ex_rs2,
    output rv_pkg::reg_idx_t  id_ex_rd,
    output rv_pkg::alu_op_e   id_ex_alu_op,
    output logic              id_ex_alu_src_imm,
    output logic              id_ex_alu_src_pc,
    output logic              id_ex_branch,
    output logic              id_ex_jump,
    output logic              id_ex_mem_read,
    output logic              id_ex_mem_write,
    output logic              id_ex_mem_unsigned,
    output logic              id_ex_reg_write,
    output rv_pkg::mem_size_e id_ex_mem_size,
    output logic [2:0]        id_ex_funct3
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      regs [1:31];
    alu_op_e    alu_fn;
    alu_op_e    alu_op;
    logic       src_imm, src_pc, branch, jump, mem_read, mem_write, reg_write;
    logic       use_rs1, use_rs2;

    assign opcode = if_id_instr[6:0];
    assign funct3 = if_id_instr[14:12];

    // Unused source fields read as x0, so no stall or forward is taken on them
    assign rs1 = use_rs1 ? if_id_instr[19:15] : 5'd0;
    assign rs2 = use_rs2 ? if_id_instr[24:20] : 5'd0;

    // ALU function from funct3, bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            F3_ADD:  alu_fn = (opcode == OPC_RTYPE && if_id_instr[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_fn = ALU_SLL;
            F3_SLT:  alu_fn = ALU_SLT;
            F3_SLTU: alu_fn = ALU_SLTU;
            F3_XOR:  alu_fn = ALU_XOR;
            F3_SRL:  alu_fn = if_id_instr[30] ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    // Main control and immediate select
    always_comb begin
        alu_op    = ALU_ADD;
        src_imm   = 1'b0;
        src_pc    = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        imm       = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
        case (opcode)
            OPC_RTYPE: begin
                alu_op    = alu_fn;
                reg_write = 1'b1;
                use_rs2   = 1'b1;
            end
            OPC_ITYPE: begin
                alu_op    = alu_fn;
                src_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OPC_LOAD: begin
                src_imm   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OPC_STORE: begin
                src_imm   = 1'b1;
                mem_write = 1'b1;
                use_rs2   = 1'b1;
                imm = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
            end
            OPC_BRANCH: begin
                branch  = 1'b1;
                use_rs2 = 1'b1;
                imm = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
                       if_id_instr[30:25], if_id_instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                // Link value is pc + 4 through the ALU
                jump      = 1'b1;
                src_pc    = 1'b1;
                reg_write = 1'b1;
                use_rs1   = 1'b0;
                imm = {{11{if_id_instr[31]}}, if_id_instr[31], if_id_instr[19:12],
                       if_id_instr[20], if_id_instr[30:21], 1'b0};
            end
            OPC_LUI: begin
                // x0 plus upper immediate
                src_imm   = 1'b1;
                reg_write = 1'b1;
                use_rs1   = 1'b0;
                imm       = {if_id_instr[31:12], 12'd0};
            end
            default: use_rs1 = 1'b0;
        endcase
    end

    // Register file, frozen under cpu_stall
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != 5'd0 && !cpu_stall) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 reads zero, same-cycle writeback passes through
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    // Load in execute feeding this instruction
    assign hazard_stall = id_ex_mem_read && id_ex_rd != 5'd0 &&
                          (id_ex_rd == rs1 || id_ex_rd == rs2);

    // ID/EX control, bubble on load-use or redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex_branch    <= 1'b0;
            id_ex_jump      <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_reg_write <= 1'b0;
        end else if (!cpu_stall) begin
            id_ex_branch    <= branch && !(hazard_stall || redirect);
            id_ex_jump      <= jump && !(hazard_stall || redirect);
            id_ex_mem_read  <= mem_read && !(hazard_stall || redirect);
            id_ex_mem_write <= mem_write && !(hazard_stall || redirect);
            id_ex_reg_write <= reg_write && !(hazard_stall || redirect);
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (!cpu_stall) begin
            id_ex_pc           <= if_id_pc;
            id_ex_rs1_data     <= rs1_data;
            id_ex_rs2_data     <= rs2_data;
            id_ex_imm          <= imm;
            id_ex_rs1          <= rs1;
            id_ex_rs2          <= rs2;
            id_ex_rd           <= if_id_instr[11:7];
            id_ex_alu_op       <= alu_op;
            id_ex_alu_src_imm  <= src_imm;
            id_ex_alu_src_pc   <= src_pc;
            id_ex_mem_unsigned <= (funct3 == F3_LBU);
            id_ex_mem_size     <= (funct3 == F3_WORD) ? MEM_WORD : MEM_BYTE;
            id_ex_funct3       <= funct3;
        end
    end

endmodule

// ==== design/execute_stage.sv ====
// Execute stage with forwarding and branch unit
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_stall,
    input  rv_pkg::word_t     id_ex_pc,
    input  rv_pkg::word_t     id_ex_rs1_data,
    input  rv_pkg::word_t     id_ex_rs2_data,
    input  rv_pkg::word_t     id_ex_imm,
    input  rv_pkg::reg_idx_t  id_ex_rs1,
    input  rv_pkg::reg_idx_t  id_ex_rs2,
    input  rv_pkg::reg_idx_t  id_ex_rd,
    input  rv_pkg::alu_op_e   id_ex_alu_op,
    input  logic              id_ex_alu_src_imm,
    input  logic              id_ex_alu_src_pc,
    input  logic              id_ex_branch,
    input  logic              id_ex_jump,
    input  logic              id_ex_mem_read,
    input  logic              id_ex_mem_write,
    input  logic              id_ex_mem_unsigned,
    input  logic              id_ex_reg_write,
    input  rv_pkg::mem_size_e id_ex_mem_size,
    input  logic [2:0]        id_ex_funct3,
    input  logic              wb_en,
    input  rv_pkg::reg_idx_t  wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              redirect,
    output rv_pkg::word_t     redirect_pc,
    output rv_pkg::word_t     ex_mem_result,
    output rv_pkg::word_t     ex_mem_store_data,
    output rv_pkg::reg_idx_t  ex_mem_rd,
    output logic              ex_mem_mem_read,
    output logic              ex_mem_mem_write,
    output logic              ex_mem_mem_unsigned,
    output logic              ex_mem_reg_write,
    output rv_pkg::mem_size_e ex_mem_mem_size
);
    import rv_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    logic  taken;

    // Youngest producer first and x0 never forwarded
    function automatic word_t fwd(input reg_idx_t idx, input word_t reg_val);
        if (idx == 5'd0) begin
            return reg_val;
        end else if (ex_mem_reg_write && ex_mem_rd == idx) begin
            return ex_mem_result;
        end else if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    always_comb begin
        rs1_val = fwd(id_ex_rs1, id_ex_rs1_data);
        rs2_val = fwd(id_ex_rs2, id_ex_rs2_data);
    end

    // jal adds 4 to its own pc for the link value
    assign op_a = id_ex_alu_src_pc ? id_ex_pc : rs1_val;
    assign op_b = id_ex_jump ? 32'd4 : (id_ex_alu_src_imm ? id_ex_imm : rs2_val);

    always_comb begin
        case (id_ex_alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'd0, op_a < op_b};
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
            default:  alu_result = op_a + op_b;
        endcase
    end

    // Branch condition on forwarded sources
    always_comb begin
        case (id_ex_funct3)
            F3_BEQ:  taken = (rs1_val == rs2_val);
            F3_BNE:  taken = (rs1_val != rs2_val);
            F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            default: taken = 1'b0;
        endcase
    end

    // Both branch and jal targets are pc relative
    assign redirect    = (id_ex_branch && taken) || id_ex_jump;
    assign redirect_pc = id_ex_pc + id_ex_imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_reg_write <= 1'b0;
        end else if (!cpu_stall) begin
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_reg_write <= id_ex_reg_write;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        if (!cpu_stall) begin
            ex_mem_result       <= alu_result;
            ex_mem_store_data   <= rs2_val;
            ex_mem_rd           <= id_ex_rd;
            ex_mem_mem_unsigned <= id_ex_mem_unsigned;
            ex_mem_mem_size     <= id_ex_mem_size;
        end
    end

endmodule

// ==== design/fetch_stage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cpu_stall,
    input  logic          hazard_stall,
    input  logic          redirect,
    input  rv_pkg::word_t redirect_pc,
    input  rv_pkg::word_t im_rdata,
    output rv_pkg::word_t im_addr,
    output rv_pkg::word_t if_id_pc,
    output rv_pkg::word_t if_id_instr
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_next;

    // Taken branch or jal from execute wins over sequential fetch
    assign pc_next = redirect ? redirect_pc : pc + 32'd4;
    assign im_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!cpu_stall) begin
            // Load-use stall holds PC unless execute redirects
            if (redirect || !hazard_stall) begin
                pc <= pc_next;
            end
        end
    end

    // IF/ID instruction, bubble after reset and on redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_instr <= NOP_INSTR;
        end else if (!cpu_stall) begin
            if (redirect) begin
                if_id_instr <= NOP_INSTR;
            end else if (!hazard_stall) begin
                if_id_instr <= im_rdata;
            end
        end
    end

    // IF/ID pc travels with the word
    always_ff @(posedge clk) begin
        if (!cpu_stall && !hazard_stall) begin
            if_id_pc <= pc;
        end
    end

endmodule

// ==== design/mem_stage.sv ====
// Memory access and writeback stage
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_stall,
    input  rv_pkg::word_t     ex_mem_result,
    input  rv_pkg::word_t     ex_mem_store_data,
    input  rv_pkg::reg_idx_t  ex_mem_rd,
    input  logic              ex_mem_mem_read,
    input  logic              ex_mem_mem_write,
    input  logic              ex_mem_mem_unsigned,
    input  logic              ex_mem_reg_write,
    input  rv_pkg::mem_size_e ex_mem_mem_size,
    input  rv_pkg::word_t     dm_rdata,
    output rv_pkg::word_t     dm_addr,
    output rv_pkg::word_t     dm_wdata,
    output logic [3:0]        dm_wstrb,
    output logic              dm_write,
    output logic              dm_read,
    output logic              wb_en,
    output rv_pkg::reg_idx_t  wb_rd,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    logic [1:0] lane;
    logic [7:0] load_byte;
    word_t      load_val;
    word_t      wb_load;
    word_t      wb_result;
    logic       wb_is_load;

    assign lane = ex_mem_result[1:0];

    // Word-aligned address, the lane is carried by the strobes
    assign dm_addr  = {ex_mem_result[31:2], 2'b00};
    assign dm_read  = ex_mem_mem_read;
    assign dm_write = ex_mem_mem_write;

    // Byte store copies the byte onto every lane
    assign dm_wdata = (ex_mem_mem_size == MEM_BYTE) ? {4{ex_mem_store_data[7:0]}}
                                                    : ex_mem_store_data;

    always_comb begin
        if (!ex_mem_mem_write) begin
            dm_wstrb = 4'b0000;
        end else if (ex_mem_mem_size == MEM_BYTE) begin
            dm_wstrb = 4'b0001 << lane;
        end else begin
            dm_wstrb = 4'b1111;
        end
    end

    // Pick the addressed byte of the read word
    always_comb begin
        case (lane)
            2'd0:    load_byte = dm_rdata[7:0];
            2'd1:    load_byte = dm_rdata[15:8];
            2'd2:    load_byte = dm_rdata[23:16];
            default: load_byte = dm_rdata[31:24];
        endcase
    end

    // lbu zero-extends, lb sign-extends
    always_comb begin
        if (ex_mem_mem_size == MEM_WORD) begin
            load_val = dm_rdata;
        end else if (ex_mem_mem_unsigned) begin
            load_val = {24'd0, load_byte};
        end else begin
            load_val = {{24{load_byte[7]}}, load_byte};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else if (!cpu_stall) begin
            wb_en <= ex_mem_reg_write;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        if (!cpu_stall) begin
            wb_rd      <= ex_mem_rd;
            wb_load    <= load_val;
            wb_result  <= ex_mem_result;
            wb_is_load <= ex_mem_mem_read;
        end
    end

    assign wb_data = wb_is_load ? wb_load : wb_result;

endmodule

// ==== design/rv_core.sv ====
// Five-stage RV32I core
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cpu_stall,
    output rv_pkg::word_t im_addr,
    input  rv_pkg::word_t im_rdata,
    output rv_pkg::word_t dm_addr,
    output rv_pkg::word_t dm_wdata,
    output logic [3:0]    dm_wstrb,
    output logic          dm_write,
    output logic          dm_read,
    input  rv_pkg::word_t dm_rdata
);
    import rv_pkg::*;

    // Fetch to decode
    word_t     if_id_pc, if_id_instr;
    logic      hazard_stall;
    // Decode to execute
    word_t     id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    reg_idx_t  id_ex_rs1, id_ex_rs2, id_ex_rd;
    alu_op_e   id_ex_alu_op;
    logic      id_ex_alu_src_imm, id_ex_alu_src_pc, id_ex_branch, id_ex_jump;
    logic      id_ex_mem_read, id_ex_mem_write, id_ex_mem_unsigned, id_ex_reg_write;
    mem_size_e id_ex_mem_size;
    logic [2:0] id_ex_funct3;
    // Execute to memory and back to fetch
    logic      redirect;
    word_t     redirect_pc, ex_mem_result, ex_mem_store_data;
    reg_idx_t  ex_mem_rd;
    logic      ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_unsigned, ex_mem_reg_write;
    mem_size_e ex_mem_mem_size;
    // Writeback
    logic      wb_en;
    reg_idx_t  wb_rd;
    word_t     wb_data;

    fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
        .clk, .rst, .cpu_stall, .hazard_stall, .redirect, .redirect_pc,
        .im_rdata, .im_addr, .if_id_pc, .if_id_instr
    );

    decode_stage i_decode (
        .clk, .rst, .cpu_stall, .redirect, .if_id_pc, .if_id_instr,
        .wb_en, .wb_rd, .wb_data, .hazard_stall,
        .id_ex_pc, .id_ex_rs1_data, .id_ex_rs2_data, .id_ex_imm,
        .id_ex_rs1, .id_ex_rs2, .id_ex_rd, .id_ex_alu_op,
        .id_ex_alu_src_imm, .id_ex_alu_src_pc, .id_ex_branch, .id_ex_jump,
        .id_ex_mem_read, .id_ex_mem_write, .id_ex_mem_unsigned, .id_ex_reg_write,
        .id_ex_mem_size, .id_ex_funct3
    );

    execute_stage i_execute (
        .clk, .rst, .cpu_stall,
        .id_ex_pc, .id_ex_rs1_data, .id_ex_rs2_data, .id_ex_imm,
        .id_ex_rs1, .id_ex_rs2, .id_ex_rd, .id_ex_alu_op,
        .id_ex_alu_src_imm, .id_ex_alu_src_pc, .id_ex_branch, .id_ex_jump,
        .id_ex_mem_read, .id_ex_mem_write, .id_ex_mem_unsigned, .id_ex_reg_write,
        .id_ex_mem_size, .id_ex_funct3, .wb_en, .wb_rd, .wb_data,
        .redirect, .redirect_pc, .ex_mem_result, .ex_mem_store_data, .ex_mem_rd,
        .ex_mem_mem_read, .ex_mem_mem_write, .ex_mem_mem_unsigned,
        .ex_mem_reg_write, .ex_mem_mem_size
    );

    mem_stage i_mem (
        .clk, .rst, .cpu_stall, .ex_mem_result, .ex_mem_store_data, .ex_mem_rd,
        .ex_mem_mem_read, .ex_mem_mem_write, .ex_mem_mem_unsigned,
        .ex_mem_reg_write, .ex_mem_mem_size, .dm_rdata,
        .dm_addr, .dm_wdata, .dm_wstrb, .dm_write, .dm_read,
        .wb_en, .wb_rd, .wb_data
    );

endmodule

// ==== design/rv_pkg.sv ====
// RV32I core shared definitions
package rv_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic {
        MEM_BYTE,
        MEM_WORD
    } mem_size_e;

    // Major opcodes
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // Load and store funct3
    localparam logic [2:0] F3_BYTE = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== src.f ====
design/rv_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/rv_core.sv
bench/rv_core_assert.sv
bench/tb_rv_core.sv
